// File: files.f
+incdir+hdl
hdl/commit_pkg.sv
hdl/commit_port0.sv
hdl/commit_port1.sv
hdl/exception_select.sv
hdl/commit_stage.sv
verification/commit_stage_tb.sv

// File: hdl/commit_params.svh
`ifndef COMMIT_PARAMS_SVH
`define COMMIT_PARAMS_SVH

// integer register data width
`define XLEN 32

// architectural register index width
`define REG_ADDR_W 5

// scoreboard transaction id width
`define TRANS_ID_W 3

// exception cause width, as handed to the CSR file
`define CAUSE_W 6

// number of retirement ports
`define NR_COMMIT_PORTS 2

`endif

// File: hdl/commit_pkg.sv
`default_nettype none

package commit_pkg;

  // functional unit an entry was issued to
  // fences and sfence.vma travel on the CSR unit
  typedef enum logic [2:0] {
    FU_NONE      = 3'd0,
    FU_ALU       = 3'd1,
    FU_LOAD      = 3'd2,
    FU_STORE     = 3'd3,
    FU_CTRL_FLOW = 3'd4,
    FU_MULT      = 3'd5,
    FU_CSR       = 3'd6
  } fu_t;

  // operation carried with the entry
  // OP_ADD doubles as the CSR no-operation
  typedef enum logic [5:0] {
    OP_ADD        = 6'd0,
    OP_SUB        = 6'd1,
    OP_AND        = 6'd2,
    OP_OR         = 6'd3,
    OP_XOR        = 6'd4,
    OP_LW         = 6'd8,
    OP_SW         = 6'd9,
    // csr access
    OP_CSRRW      = 6'd16,
    OP_CSRRS      = 6'd17,
    OP_CSRRC      = 6'd18,
    // ordering and translation flushes
    OP_FENCE      = 6'd24,
    OP_FENCE_I    = 6'd25,
    OP_SFENCE_VMA = 6'd26
  } op_t;

endpackage

`default_nettype wire

// File: hdl/commit_port0.sv
`timescale 1ns/1ps
`default_nettype none

`include "commit_params.svh"

module commit_port0
  import commit_pkg::*;
(
  // oldest scoreboard entry
  input  wire logic              instr0_valid_i,
  input  wire fu_t               instr0_fu_i,
  input  wire op_t               instr0_op_i,
  input  wire logic [`XLEN-1:0]  instr0_result_i,
  input  wire logic              instr0_ex_valid_i,
  input  wire logic              drop0_i,
  // controller
  input  wire logic              halt_i,
  // LSU
  input  wire logic              commit_lsu_ready_i,
  input  wire logic              no_st_pending_i,
  // CSR file
  input  wire logic [`XLEN-1:0]  csr_rdata_i,
  input  wire logic              csr_exception_valid_i,
  // retirement
  output logic                   ack_o,
  output logic                   pair_ok_o,
  output logic                   we_o,
  output logic [`XLEN-1:0]       wdata_o,
  // side effects
  output op_t                    csr_op_o,
  output logic [`XLEN-1:0]       csr_wdata_o,
  output logic                   commit_csr_o,
  output logic                   commit_lsu_o,
  output logic                   fence_o,
  output logic                   fence_i_o,
  output logic                   sfence_vma_o
);

  // -------------------------------------------------------------------------
  // retire decision for the oldest entry
  // -------------------------------------------------------------------------
  always_comb begin
    // nothing retires and no side effect by default
    ack_o        = 1'b0;
    we_o         = 1'b0;
    wdata_o      = instr0_result_i;
    // csr file sees a no-op unless a CSR entry is at the head
    csr_op_o     = OP_ADD;
    csr_wdata_o  = '0;
    commit_csr_o = 1'b0;
    commit_lsu_o = 1'b0;
    fence_o      = 1'b0;
    fence_i_o    = 1'b0;
    sfence_vma_o = 1'b0;

    // a halt request freezes retirement entirely
    if (instr0_valid_i && !halt_i) begin
      if (instr0_ex_valid_i) begin
        // faulting entry only leaves the scoreboard when it is being dropped,
        // otherwise the trap is taken and the issue stage flushes it
        ack_o = drop0_i;
      end else begin
        ack_o = 1'b1;
        // a dropped entry retires without touching the register file
        we_o  = !drop0_i;

        // store is released to the store buffer, hold it while the buffer is full
        if (instr0_fu_i == FU_STORE) begin
          if (commit_lsu_ready_i) begin
            commit_lsu_o = 1'b1;
          end else begin
            ack_o = 1'b0;
          end
        end

        // -------------------------------------------------------------------------
        // csr access
        // -------------------------------------------------------------------------
        if (instr0_fu_i == FU_CSR) begin
          csr_op_o    = instr0_op_i;
          csr_wdata_o = instr0_result_i;
          if (!drop0_i) begin
            if (!csr_exception_valid_i) begin
              // old csr value goes to rd
              commit_csr_o = 1'b1;
              wdata_o      = csr_rdata_i;
            end else begin
              // csr file refused the access, the trap path takes over
              ack_o = 1'b0;
              we_o  = 1'b0;
            end
          end
        end

        // -------------------------------------------------------------------------
        // fences
        // -------------------------------------------------------------------------
        // all three are idempotent, so they simply wait for the store
        // buffer to drain and are re-presented until then
        if (!drop0_i) begin
          case (instr0_op_i)
            OP_FENCE: begin
              ack_o   = no_st_pending_i;
              fence_o = no_st_pending_i;
            end
            OP_FENCE_I: begin
              ack_o     = no_st_pending_i;
              fence_i_o = no_st_pending_i;
            end
            OP_SFENCE_VMA: begin
              ack_o        = no_st_pending_i;
              sfence_vma_o = no_st_pending_i;
            end
            default: begin
              // no ordering needed
            end
          endcase
        end
      end
    end
  end

  // second port may follow only a retiring non-CSR entry,
  // this also keeps it behind every fence
  assign pair_ok_o = ack_o && (instr0_fu_i != FU_CSR);

endmodule

`default_nettype wire

// File: hdl/commit_port1.sv
`timescale 1ns/1ps
`default_nettype none

`include "commit_params.svh"

module commit_port1
  import commit_pkg::*;
(
  // second oldest scoreboard entry
  input  wire logic              instr1_valid_i,
  input  wire fu_t               instr1_fu_i,
  input  wire logic [`XLEN-1:0]  instr1_result_i,
  input  wire logic              instr1_ex_valid_i,
  input  wire logic              drop1_i,
  // port 0 retires and allows a partner
  input  wire logic              pair_ok_i,
  // debug single step retires one instruction at a time
  input  wire logic              single_step_i,
  output logic                   ack_o,
  output logic                   we_o,
  output logic [`XLEN-1:0]       wdata_o
);

  logic simple_fu;

  // -------------------------------------------------------------------------
  // dual retire eligibility
  // -------------------------------------------------------------------------
  // only units with no side effect beyond the register write may pair up
  always_comb begin
    case (instr1_fu_i)
      FU_ALU, FU_LOAD, FU_CTRL_FLOW, FU_MULT: simple_fu = 1'b1;
      default:                                simple_fu = 1'b0;
    endcase
  end

  // a faulting entry always waits for port 0, where traps are taken
  assign ack_o = pair_ok_i
              && instr1_valid_i
              && !single_step_i
              && !instr1_ex_valid_i
              && simple_fu;

  // dropped entries still leave the scoreboard, just without the write
  assign we_o    = ack_o && !drop1_i;
  assign wdata_o = instr1_result_i;

endmodule

`default_nettype wire

// File: hdl/commit_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "commit_params.svh"

module commit_stage
  import commit_pkg::*;
(
  // entry 0, oldest in the scoreboard
  input  wire logic                          instr0_valid_i,
  input  wire fu_t                           instr0_fu_i,
  input  wire op_t                           instr0_op_i,
  input  wire logic [`REG_ADDR_W-1:0]        instr0_rd_i,
  input  wire logic [`XLEN-1:0]              instr0_result_i,
  input  wire logic                          instr0_ex_valid_i,
  input  wire logic [`CAUSE_W-1:0]           instr0_ex_cause_i,
  input  wire logic [`XLEN-1:0]              instr0_ex_tval_i,
  input  wire logic [`XLEN-1:0]              instr0_pc_i,
  input  wire logic [`TRANS_ID_W-1:0]        instr0_trans_id_i,
  // entry 1
  input  wire logic                          instr1_valid_i,
  input  wire fu_t                           instr1_fu_i,
  input  wire logic [`REG_ADDR_W-1:0]        instr1_rd_i,
  input  wire logic [`XLEN-1:0]              instr1_result_i,
  input  wire logic                          instr1_ex_valid_i,
  input  wire logic [`NR_COMMIT_PORTS-1:0]   commit_drop_i,
  // controller
  input  wire logic                          halt_i,
  input  wire logic                          single_step_i,
  // LSU
  input  wire logic                          commit_lsu_ready_i,
  input  wire logic                          no_st_pending_i,
  // CSR file
  input  wire logic [`XLEN-1:0]              csr_rdata_i,
  input  wire logic                          csr_exception_valid_i,
  input  wire logic [`CAUSE_W-1:0]           csr_exception_cause_i,
  // retirement towards issue stage and register file
  output logic [`NR_COMMIT_PORTS-1:0]                  commit_ack_o,
  output logic [`NR_COMMIT_PORTS-1:0]                  we_gpr_o,
  output logic [`NR_COMMIT_PORTS-1:0][`REG_ADDR_W-1:0] waddr_o,
  output logic [`NR_COMMIT_PORTS-1:0][`XLEN-1:0]       wdata_o,
  output logic [`XLEN-1:0]                             pc_o,
  output logic [`TRANS_ID_W-1:0]                       commit_tran_id_o,
  // side effects
  output op_t                                          csr_op_o,
  output logic [`XLEN-1:0]                             csr_wdata_o,
  output logic                                         commit_csr_o,
  output logic                                         commit_lsu_o,
  output logic                                         fence_o,
  output logic                                         fence_i_o,
  output logic                                         sfence_vma_o,
  // trap
  output logic                                         exception_valid_o,
  output logic [`CAUSE_W-1:0]                          exception_cause_o,
  output logic [`XLEN-1:0]                             exception_tval_o
);

  logic             ack0;
  logic             ack1;
  logic             we0;
  logic             we1;
  logic [`XLEN-1:0] wdata0;
  logic [`XLEN-1:0] wdata1;
  logic             pair_ok;

  // -------------------------------------------------------------------------
  // port 0, full retirement with side effects
  // -------------------------------------------------------------------------
  commit_port0 u_port0 (
    .instr0_valid_i        (instr0_valid_i),
    .instr0_fu_i           (instr0_fu_i),
    .instr0_op_i           (instr0_op_i),
    .instr0_result_i       (instr0_result_i),
    .instr0_ex_valid_i     (instr0_ex_valid_i),
    .drop0_i               (commit_drop_i[0]),
    .halt_i                (halt_i),
    .commit_lsu_ready_i    (commit_lsu_ready_i),
    .no_st_pending_i       (no_st_pending_i),
    .csr_rdata_i           (csr_rdata_i),
    .csr_exception_valid_i (csr_exception_valid_i),
    .ack_o                 (ack0),
    .pair_ok_o             (pair_ok),
    .we_o                  (we0),
    .wdata_o               (wdata0),
    .csr_op_o              (csr_op_o),
    .csr_wdata_o           (csr_wdata_o),
    .commit_csr_o          (commit_csr_o),
    .commit_lsu_o          (commit_lsu_o),
    .fence_o               (fence_o),
    .fence_i_o             (fence_i_o),
    .sfence_vma_o          (sfence_vma_o)
  );

  // port 1 only ever pairs with a retiring port 0
  commit_port1 u_port1 (
    .instr1_valid_i    (instr1_valid_i),
    .instr1_fu_i       (instr1_fu_i),
    .instr1_result_i   (instr1_result_i),
    .instr1_ex_valid_i (instr1_ex_valid_i),
    .drop1_i           (commit_drop_i[1]),
    .pair_ok_i         (pair_ok),
    .single_step_i     (single_step_i),
    .ack_o             (ack1),
    .we_o              (we1),
    .wdata_o           (wdata1)
  );

  exception_select u_exc (
    .instr0_valid_i        (instr0_valid_i),
    .drop0_i               (commit_drop_i[0]),
    .halt_i                (halt_i),
    .instr0_ex_valid_i     (instr0_ex_valid_i),
    .instr0_ex_cause_i     (instr0_ex_cause_i),
    .instr0_ex_tval_i      (instr0_ex_tval_i),
    .csr_exception_valid_i (csr_exception_valid_i),
    .csr_exception_cause_i (csr_exception_cause_i),
    .exception_valid_o     (exception_valid_o),
    .exception_cause_o     (exception_cause_o),
    .exception_tval_o      (exception_tval_o)
  );

  // per port vectors, port 0 in the low slot
  assign commit_ack_o = {ack1, ack0};
  assign we_gpr_o     = {we1, we0};
  assign wdata_o      = {wdata1, wdata0};
  assign waddr_o      = {instr1_rd_i, instr0_rd_i};

  // head entry identity for the CSR file and the scoreboard
  assign pc_o             = instr0_pc_i;
  assign commit_tran_id_o = instr0_trans_id_i;

endmodule

`default_nettype wire

// File: hdl/exception_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "commit_params.svh"

module exception_select (
  // oldest entry
  input  wire logic                instr0_valid_i,
  input  wire logic                drop0_i,
  input  wire logic                halt_i,
  input  wire logic                instr0_ex_valid_i,
  input  wire logic [`CAUSE_W-1:0] instr0_ex_cause_i,
  input  wire logic [`XLEN-1:0]    instr0_ex_tval_i,
  // CSR file
  input  wire logic                csr_exception_valid_i,
  input  wire logic [`CAUSE_W-1:0] csr_exception_cause_i,
  // trap reported to the CSR file
  output logic                     exception_valid_o,
  output logic [`CAUSE_W-1:0]      exception_cause_o,
  output logic [`XLEN-1:0]         exception_tval_o
);

  // -------------------------------------------------------------------------
  // exception priority
  // -------------------------------------------------------------------------
  always_comb begin
    exception_valid_o = 1'b0;
    exception_cause_o = '0;
    exception_tval_o  = '0;

    // only a live head entry can trap
    if (instr0_valid_i && !drop0_i) begin
      // without an earlier fault tval still holds the instruction bits
      if (csr_exception_valid_i) begin
        exception_valid_o = 1'b1;
        exception_cause_o = csr_exception_cause_i;
        exception_tval_o  = instr0_ex_tval_i;
      end
      // earlier faults (fetch, decode, page faults) win
      if (instr0_ex_valid_i) begin
        exception_valid_o = 1'b1;
        exception_cause_o = instr0_ex_cause_i;
        exception_tval_o  = instr0_ex_tval_i;
      end
    end

    // no trap while the core is halted
    if (halt_i) begin
      exception_valid_o = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the commit stage testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing -sv \
  -f files.f \
  --top-module commit_stage_tb \
  --Mdir "$BUILD_DIR" \
  -o Vcommit_stage_tb

# a failing run exits non-zero, the log is inspected below
"./$BUILD_DIR/Vcommit_stage_tb" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
grep -q "Simulation passed" "$LOG"

// File: verification/commit_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "commit_params.svh"

module commit_stage_tb
  import commit_pkg::*;
();

  localparam int NUM_TESTS   = 3000;
  // one test per clock with reset and some slack on top
  localparam int WATCHDOG_NS = NUM_TESTS * 10 + 4 * 10 + 200;

  // expected value of every DUT output
  typedef struct packed {
    logic                   ack0;
    logic                   ack1;
    logic                   we0;
    logic                   we1;
    logic [`REG_ADDR_W-1:0] waddr0;
    logic [`REG_ADDR_W-1:0] waddr1;
    logic [`XLEN-1:0]       wdata0;
    logic [`XLEN-1:0]       wdata1;
    logic [`XLEN-1:0]       pc;
    logic [`TRANS_ID_W-1:0] tran_id;
    op_t                    csr_op;
    logic [`XLEN-1:0]       csr_wdata;
    logic                   commit_csr;
    logic                   commit_lsu;
    logic                   fence;
    logic                   fence_i;
    logic                   sfence_vma;
    logic                   exc_valid;
    logic [`CAUSE_W-1:0]    exc_cause;
    logic [`XLEN-1:0]       exc_tval;
  } expect_t;

  logic clk_i;
  logic reset_i;

  // DUT inputs
  logic                              instr0_valid_i;
  fu_t                               instr0_fu_i;
  op_t                               instr0_op_i;
  logic [`REG_ADDR_W-1:0]            instr0_rd_i;
  logic [`XLEN-1:0]                  instr0_result_i;
  logic                              instr0_ex_valid_i;
  logic [`CAUSE_W-1:0]               instr0_ex_cause_i;
  logic [`XLEN-1:0]                  instr0_ex_tval_i;
  logic [`XLEN-1:0]                  instr0_pc_i;
  logic [`TRANS_ID_W-1:0]            instr0_trans_id_i;
  logic                              instr1_valid_i;
  fu_t                               instr1_fu_i;
  logic [`REG_ADDR_W-1:0]            instr1_rd_i;
  logic [`XLEN-1:0]                  instr1_result_i;
  logic                              instr1_ex_valid_i;
  logic [`NR_COMMIT_PORTS-1:0]       commit_drop_i;
  logic                              halt_i;
  logic                              single_step_i;
  logic                              commit_lsu_ready_i;
  logic                              no_st_pending_i;
  logic [`XLEN-1:0]                  csr_rdata_i;
  logic                              csr_exception_valid_i;
  logic [`CAUSE_W-1:0]               csr_exception_cause_i;

  // DUT outputs
  logic [`NR_COMMIT_PORTS-1:0]                  commit_ack_o;
  logic [`NR_COMMIT_PORTS-1:0]                  we_gpr_o;
  logic [`NR_COMMIT_PORTS-1:0][`REG_ADDR_W-1:0] waddr_o;
  logic [`NR_COMMIT_PORTS-1:0][`XLEN-1:0]       wdata_o;
  logic [`XLEN-1:0]                             pc_o;
  logic [`TRANS_ID_W-1:0]                       commit_tran_id_o;
  op_t                                          csr_op_o;
  logic [`XLEN-1:0]                             csr_wdata_o;
  logic                                         commit_csr_o;
  logic                                         commit_lsu_o;
  logic                                         fence_o;
  logic                                         fence_i_o;
  logic                                         sfence_vma_o;
  logic                                         exception_valid_o;
  logic [`CAUSE_W-1:0]                          exception_cause_o;
  logic [`XLEN-1:0]                             exception_tval_o;

  logic [15:0] lfsr_state;
  int          checks_done;
  expect_t     want;

  commit_stage u_dut (.*);

  always #5 clk_i = ~clk_i;

  // -------------------------------------------------------------------------
  // random source
  // -------------------------------------------------------------------------
  // 16 bit galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic lsb;
    lsb = s[0];
    s   = s >> 1;
    if (lsb) begin
      s = s ^ 16'hB400;
    end
    return s;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r          = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // entry 0 kinds
  // CSR access and fences both issue on the CSR unit
  function automatic fu_t entry0_fu(input logic [2:0] k);
    case (k)
      3'd0:       return FU_ALU;
      3'd1:       return FU_LOAD;
      3'd2:       return FU_STORE;
      3'd3:       return FU_CTRL_FLOW;
      3'd4:       return FU_MULT;
      3'd5, 3'd6: return FU_CSR;
      default:    return FU_NONE;
    endcase
  endfunction

  function automatic op_t entry0_op(input logic [2:0] k, input logic [1:0] sel);
    op_t alu_ops [4];
    op_t csr_ops [4];
    op_t fen_ops [4];
    alu_ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR};
    // last slot is the csr no-op
    csr_ops = '{OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_ADD};
    fen_ops = '{OP_FENCE, OP_FENCE_I, OP_SFENCE_VMA, OP_SFENCE_VMA};
    case (k)
      3'd0:    return alu_ops[sel];
      3'd1:    return OP_LW;
      3'd2:    return OP_SW;
      3'd5:    return csr_ops[sel];
      3'd6:    return fen_ops[sel];
      default: return OP_ADD;
    endcase
  endfunction

  // entry 1 also gets ineligible units now and then
  function automatic fu_t entry1_fu(input logic [2:0] k);
    case (k)
      3'd0:    return FU_ALU;
      3'd1:    return FU_LOAD;
      3'd2:    return FU_CTRL_FLOW;
      3'd3:    return FU_MULT;
      3'd4:    return FU_STORE;
      3'd5:    return FU_CSR;
      3'd6:    return FU_NONE;
      default: return FU_ALU;
    endcase
  endfunction

  task automatic drive_random();
    logic [2:0] k0;
    logic [2:0] k1;
    k0 = 3'(take_bits(3));
    k1 = 3'(take_bits(3));
    instr0_valid_i        = take_bits(3) != 0;
    instr0_fu_i           = entry0_fu(k0);
    instr0_op_i           = entry0_op(k0, 2'(take_bits(2)));
    instr0_rd_i           = `REG_ADDR_W'(take_bits(`REG_ADDR_W));
    instr0_result_i       = take_bits(`XLEN);
    instr0_ex_valid_i     = take_bits(3) == 0;
    instr0_ex_cause_i     = `CAUSE_W'(take_bits(`CAUSE_W));
    instr0_ex_tval_i      = take_bits(`XLEN);
    instr0_pc_i           = take_bits(`XLEN);
    instr0_trans_id_i     = `TRANS_ID_W'(take_bits(`TRANS_ID_W));
    instr1_valid_i        = take_bits(3) != 0;
    instr1_fu_i           = entry1_fu(k1);
    instr1_rd_i           = `REG_ADDR_W'(take_bits(`REG_ADDR_W));
    instr1_result_i       = take_bits(`XLEN);
    instr1_ex_valid_i     = take_bits(3) == 0;
    commit_drop_i         = {take_bits(2) == 0, take_bits(2) == 0};
    halt_i                = take_bits(3) == 0;
    single_step_i         = take_bits(2) == 0;
    commit_lsu_ready_i    = take_bits(2) != 0;
    no_st_pending_i       = take_bits(2) != 0;
    csr_rdata_i           = take_bits(`XLEN);
    csr_exception_valid_i = take_bits(2) == 0;
    csr_exception_cause_i = `CAUSE_W'(take_bits(`CAUSE_W));
  endtask

  // -------------------------------------------------------------------------
  // reference model of the retirement rules
  // -------------------------------------------------------------------------
  function automatic expect_t expected_outputs();
    expect_t e;
    logic    pair_ok;
    logic    simple1;
    e           = '0;
    e.waddr0    = instr0_rd_i;
    e.waddr1    = instr1_rd_i;
    e.wdata0    = instr0_result_i;
    e.wdata1    = instr1_result_i;
    e.pc        = instr0_pc_i;
    e.tran_id   = instr0_trans_id_i;
    e.csr_op    = OP_ADD;
    if (instr0_valid_i && !halt_i) begin
      if (instr0_ex_valid_i) begin
        e.ack0 = commit_drop_i[0];
      end else begin
        e.ack0 = 1'b1;
        e.we0  = !commit_drop_i[0];
        // store waits for room in the LSU
        if (instr0_fu_i == FU_STORE) begin
          e.commit_lsu = commit_lsu_ready_i;
          e.ack0       = commit_lsu_ready_i;
        end
        if (instr0_fu_i == FU_CSR) begin
          e.csr_op    = instr0_op_i;
          e.csr_wdata = instr0_result_i;
          if (!commit_drop_i[0] && !csr_exception_valid_i) begin
            e.commit_csr = 1'b1;
            e.wdata0     = csr_rdata_i;
          end else if (!commit_drop_i[0]) begin
            e.ack0 = 1'b0;
            e.we0  = 1'b0;
          end
        end
        // fences wait for the store buffer to drain
        if (!commit_drop_i[0] && instr0_op_i inside {OP_FENCE, OP_FENCE_I, OP_SFENCE_VMA}) begin
          e.ack0       = no_st_pending_i;
          e.fence      = no_st_pending_i && (instr0_op_i == OP_FENCE);
          e.fence_i    = no_st_pending_i && (instr0_op_i == OP_FENCE_I);
          e.sfence_vma = no_st_pending_i && (instr0_op_i == OP_SFENCE_VMA);
        end
      end
    end
    pair_ok = e.ack0 && (instr0_fu_i != FU_CSR);
    simple1 = instr1_fu_i inside {FU_ALU, FU_LOAD, FU_CTRL_FLOW, FU_MULT};
    e.ack1  = pair_ok && instr1_valid_i && !single_step_i && !instr1_ex_valid_i && simple1;
    e.we1   = e.ack1 && !commit_drop_i[1];
    // earlier fault beats the CSR fault
    // tval always comes from entry 0
    if (instr0_valid_i && !commit_drop_i[0]) begin
      if (instr0_ex_valid_i || csr_exception_valid_i) begin
        e.exc_valid = 1'b1;
        e.exc_tval  = instr0_ex_tval_i;
        e.exc_cause = instr0_ex_valid_i ? instr0_ex_cause_i : csr_exception_cause_i;
      end
    end
    if (halt_i) begin
      e.exc_valid = 1'b0;
    end
    return e;
  endfunction

  task automatic check_value(input string field, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAIL test %0d %s expected 0x%0h actual 0x%0h",
               checks_done, field, expected, actual);
      $display("Simulation failed");
      $fatal(1, "output mismatch");
    end
  endtask

  // -------------------------------------------------------------------------
  // compare on the rising edge with inputs settled since the falling edge
  // -------------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (!reset_i) begin
      want = expected_outputs();
      check_value("ack0", 64'(want.ack0), 64'(commit_ack_o[0]));
      check_value("ack1", 64'(want.ack1), 64'(commit_ack_o[1]));
      check_value("we0", 64'(want.we0), 64'(we_gpr_o[0]));
      check_value("we1", 64'(want.we1), 64'(we_gpr_o[1]));
      check_value("waddr0", 64'(want.waddr0), 64'(waddr_o[0]));
      check_value("waddr1", 64'(want.waddr1), 64'(waddr_o[1]));
      check_value("wdata0", 64'(want.wdata0), 64'(wdata_o[0]));
      check_value("wdata1", 64'(want.wdata1), 64'(wdata_o[1]));
      check_value("pc", 64'(want.pc), 64'(pc_o));
      check_value("tran_id", 64'(want.tran_id), 64'(commit_tran_id_o));
      check_value("csr_op", 64'(want.csr_op), 64'(csr_op_o));
      check_value("csr_wdata", 64'(want.csr_wdata), 64'(csr_wdata_o));
      check_value("commit_csr", 64'(want.commit_csr), 64'(commit_csr_o));
      check_value("commit_lsu", 64'(want.commit_lsu), 64'(commit_lsu_o));
      check_value("fence", 64'(want.fence), 64'(fence_o));
      check_value("fence_i", 64'(want.fence_i), 64'(fence_i_o));
      check_value("sfence_vma", 64'(want.sfence_vma), 64'(sfence_vma_o));
      check_value("exc_valid", 64'(want.exc_valid), 64'(exception_valid_o));
      check_value("exc_cause", 64'(want.exc_cause), 64'(exception_cause_o));
      check_value("exc_tval", 64'(want.exc_tval), 64'(exception_tval_o));
      checks_done++;
    end
  end

  // stimulus on the falling edge
  initial begin
    clk_i                 = 1'b0;
    reset_i               = 1'b1;
    checks_done           = 0;
    lfsr_state            = 16'd22;
    instr0_valid_i        = 1'b0;
    instr0_fu_i           = FU_NONE;
    instr0_op_i           = OP_ADD;
    instr0_rd_i           = '0;
    instr0_result_i       = '0;
    instr0_ex_valid_i     = 1'b0;
    instr0_ex_cause_i     = '0;
    instr0_ex_tval_i      = '0;
    instr0_pc_i           = '0;
    instr0_trans_id_i     = '0;
    instr1_valid_i        = 1'b0;
    instr1_fu_i           = FU_NONE;
    instr1_rd_i           = '0;
    instr1_result_i       = '0;
    instr1_ex_valid_i     = 1'b0;
    commit_drop_i         = '0;
    halt_i                = 1'b0;
    single_step_i         = 1'b0;
    commit_lsu_ready_i    = 1'b0;
    no_st_pending_i       = 1'b0;
    csr_rdata_i           = '0;
    csr_exception_valid_i = 1'b0;
    csr_exception_cause_i = '0;
    // checking starts with the first entry after four reset cycles
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    drive_random();
    for (int i = 1; i < NUM_TESTS; i++) begin
      @(negedge clk_i);
      drive_random();
    end
    @(posedge clk_i);
    #1;
    if (checks_done == NUM_TESTS) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("only %0d of %0d tests were checked", checks_done, NUM_TESTS);
      $display("Simulation failed");
      $fatal(1, "incomplete run");
    end
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all tests finished");
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire
